// File: design/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;   // Data and address width

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {
        imm_i = 2'b00,   // Loads and immediate arithmetic
        imm_s = 2'b01,   // Stores
        imm_b = 2'b10    // Branches
    } imm_src_e;

    // Coarse ALU work requested by the main decoder
    typedef enum logic [1:0] {
        alu_cls_add  = 2'b00,   // Address arithmetic
        alu_cls_sub  = 2'b01,   // Branch compare
        alu_cls_func = 2'b10    // Function fields decide
    } alu_class_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101
    } alu_op_e;

    // Main control word
    typedef struct packed {
        logic       reg_wr_en;
        logic       mem_wr_en;
        imm_src_e   imm_src;
        logic       alu_src;      // 1 selects the immediate
        logic       branch;
        logic       result_src;   // 1 selects load data
        alu_class_e alu_class;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // One instruction word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

// File: design/main_decoder.sv
module main_decoder import rv_pkg::*; (
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    always_comb begin
        // Everything inactive unless the opcode is recognised
        ctrl.reg_wr_en  = 1'b0;
        ctrl.mem_wr_en  = 1'b0;
        ctrl.imm_src    = imm_i;
        ctrl.alu_src    = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.result_src = 1'b0;
        ctrl.alu_class  = alu_cls_add;

        case (opcode)
            op_load: begin   // lw
                ctrl.reg_wr_en  = 1'b1;
                ctrl.imm_src    = imm_i;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = 1'b1;   // Write back load data
                ctrl.alu_class  = alu_cls_add;
            end

            op_imm: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.imm_src   = imm_i;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = alu_cls_func;
            end

            op_store: begin   // sw
                ctrl.mem_wr_en = 1'b1;
                ctrl.imm_src   = imm_s;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = alu_cls_add;
            end

            op_reg: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_src   = 1'b0;
                ctrl.alu_class = alu_cls_func;
            end

            // beq compares by subtraction
            op_branch: begin
                ctrl.imm_src   = imm_b;
                ctrl.branch    = 1'b1;
                ctrl.alu_class = alu_cls_sub;
            end

            default: ;   // Unknown opcode acts as a bubble
        endcase
    end

endmodule

// File: design/alu_decoder.sv
module alu_decoder import rv_pkg::*; (
    input  alu_class_e alu_class,
    input  logic [2:0] funct3,
    input  logic       funct7_b5,
    input  logic       op_b5,
    output alu_op_e    alu_op
);

    logic is_sub;

    // Only the register form with funct7[5] set is a subtract
    assign is_sub = funct7_b5 & op_b5;

    always_comb begin
        case (alu_class)
            alu_cls_add: alu_op = alu_add;
            alu_cls_sub: alu_op = alu_sub;
            alu_cls_func: begin
                case (funct3)
                    3'b000:  alu_op = is_sub ? alu_sub : alu_add;   // add, sub, addi
                    3'b010:  alu_op = alu_slt;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
            end
            default: alu_op = alu_add;
        endcase
    end

endmodule

// File: design/imm_extend.sv
module imm_extend import rv_pkg::*; (
    input  instr_u          instr,
    input  imm_src_e        imm_src,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (imm_src)
            imm_i: imm = {{(xlen-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

            imm_s: imm = {{(xlen-12){instr.s_fmt.imm_hi[6]}},
                          instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};

            // Branch offsets are in halfwords, bit 0 always zero
            imm_b: imm = {{(xlen-13){instr.b_fmt.imm_12}},
                          instr.b_fmt.imm_12,
                          instr.b_fmt.imm_11,
                          instr.b_fmt.imm_10_5,
                          instr.b_fmt.imm_4_1,
                          1'b0};

            default: imm = '0;
        endcase
    end

endmodule

// File: design/reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  logic [4:0]      wa,
    input  logic            we,
    input  logic [xlen-1:0] wd,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);

    logic [xlen-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // x0 always reads as zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: design/alu.sv
module alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] y,
    output logic            zero
);

    logic lt;

    assign lt = $signed(a) < $signed(b);   // Signed compare for slt

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_slt: y = {{(xlen-1){1'b0}}, lt};
            default: y = '0;
        endcase
    end

    // Used by beq after a subtract
    assign zero = (y == '0);

endmodule

// File: design/rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    input  logic [xlen-1:0] dmem_rdata
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    instr_u          instr;
    opcode_e         opcode;
    ctrl_t           ctrl;
    alu_op_e         alu_op;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic            alu_zero;
    logic [xlen-1:0] result;
    logic            reg_we;

    assign instr  = imem_data;
    assign opcode = opcode_e'(instr.r_fmt.opcode);

    // Taken branch adds the B offset, otherwise next word
    assign pc_next = (ctrl.branch && alu_zero) ? pc + imm : pc + xlen'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;

    main_decoder u_main_decoder (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    alu_decoder u_alu_decoder (
        .alu_class (ctrl.alu_class),
        .funct3    (instr.r_fmt.funct3),
        .funct7_b5 (instr.r_fmt.funct7[5]),
        .op_b5     (instr.r_fmt.opcode[5]),   // Separates add from addi
        .alu_op    (alu_op)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    // No architectural writes while in reset
    assign reg_we  = ctrl.reg_wr_en & ~rst;
    assign dmem_we = ctrl.mem_wr_en & ~rst;

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .ra1 (instr.r_fmt.rs1),
        .ra2 (instr.r_fmt.rs2),
        .wa  (instr.r_fmt.rd),
        .we  (reg_we),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign alu_b = ctrl.alu_src ? imm : rd2;

    alu u_alu (
        .a    (rd1),
        .b    (alu_b),
        .op   (alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    assign dmem_addr  = alu_y;
    assign dmem_wdata = rd2;   // sw data comes from rs2

    assign result = ctrl.result_src ? dmem_rdata : alu_y;

endmodule

// File: sim/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int prog_len      = 39;
    localparam int store_timeout = 200;
    localparam logic [31:0] nop_word = 32'h0000_0013;   // addi x0, x0, 0

    // Program from address 0, one word per entry
    localparam logic [0:prog_len-1][31:0] prog = {
        32'h0800_2423,   // 00 sw x0, 0x88(x0) sits at the reset PC
        32'hFFB0_0093,   // 04 addi x1, x0, -5
        32'hFF00_F113,   // 08 andi x2, x1, -16
        32'hF000_6193,   // 0c ori  x3, x0, -256
        32'hFFC0_A213,   // 10 slti x4, x1, -4
        32'h0410_2023,   // 14 sw x1, 0x40(x0)
        32'h0420_2223,   // 18 sw x2, 0x44(x0)
        32'h0430_2423,   // 1c sw x3, 0x48(x0)
        32'h0440_2623,   // 20 sw x4, 0x4c(x0)
        32'h0640_0293,   // 24 addi x5, x0, 100
        32'h0050_8333,   // 28 add x6, x1, x5
        32'h4050_83B3,   // 2c sub x7, x1, x5
        32'h0051_7433,   // 30 and x8, x2, x5
        32'h0051_E4B3,   // 34 or  x9, x3, x5
        32'h0050_A533,   // 38 slt x10, x1, x5
        32'h0012_A5B3,   // 3c slt x11, x5, x1
        32'h0460_2823,   // 40 sw x6, 0x50(x0)
        32'h0470_2A23,   // 44 sw x7, 0x54(x0)
        32'h0480_2C23,   // 48 sw x8, 0x58(x0)
        32'h0490_2E23,   // 4c sw x9, 0x5c(x0)
        32'h06A0_2023,   // 50 sw x10, 0x60(x0)
        32'h06B0_2223,   // 54 sw x11, 0x64(x0)
        32'h0080_2603,   // 58 lw x12, 8(x0)
        32'h0700_0793,   // 5c addi x15, x0, 0x70
        32'h0056_06B3,   // 60 add x13, x12, x5
        32'hFED7_AE23,   // 64 sw x13, -4(x15)
        32'h0050_8463,   // 68 beq x1, x5, +8 (not taken)
        32'h0650_2823,   // 6c sw x5, 0x70(x0)
        32'h0052_8463,   // 70 beq x5, x5, +8 (taken)
        32'h0610_2A23,   // 74 sw x1, 0x74(x0) must be skipped
        32'h0030_0813,   // 78 addi x16, x0, 3
        32'h0010_0993,   // 7c addi x19, x0, 1
        32'h0058_8893,   // 80 addi x17, x17, 5
        32'h0910_2023,   // 84 sw x17, 0x80(x0)
        32'hFFF8_0813,   // 88 addi x16, x16, -1
        32'h0100_2933,   // 8c slt x18, x0, x16
        32'hFF39_08E3,   // 90 beq x18, x19, -16
        32'h07B0_0013,   // 94 addi x0, x0, 123
        32'h0800_2223    // 98 sw x0, 0x84(x0)
    };

    // Branch sites, offsets and taken counts for the reference PC
    localparam logic [0:2][31:0] br_pc    = {32'h68, 32'h70, 32'h90};
    localparam logic [0:2][31:0] br_off   = {32'd8, 32'd8, 32'hFFFF_FFF0};
    localparam logic [0:2][3:0]  br_taken = {4'd0, 4'd1, 4'd2};

    localparam logic [31:0] x1_val = 32'hFFFF_FFFB;   // -5
    localparam logic [31:0] x2_val = x1_val & 32'hFFFF_FFF0;
    localparam logic [31:0] x3_val = 32'hFFFF_FF00;
    localparam logic [31:0] x5_val = 32'd100;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] ref_pc = '0;
    int          taken_left [0:2];
    int          seed = 84;   // Kept for random stimulus later

    rv_core u_rv_core (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #20 clk = ~clk;

    assign imem_data  = (imem_addr < prog_len * 4) ? prog[imem_addr[7:2]] : nop_word;
    assign dmem_rdata = dmem[dmem_addr[7:2]];   // Combinational read

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {8'hC3, a, a ^ 8'h5A, ~a};
    endfunction

    function automatic logic [31:0] slt_ref(input logic [31:0] a, input logic [31:0] b);
        // Differing signs decide directly, otherwise plain magnitude
        if (a[31] != b[31]) begin
            return {31'd0, a[31]};
        end
        return {31'd0, a < b};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Reset watch, then reference PC every cycle
    always @(negedge clk) begin : pc_model
        logic [31:0] next_pc;
        if (rst) begin
            assert (dmem_we === 1'b0) else report_failure("a store was issued during reset");
        end else begin
            assert (imem_addr === ref_pc)
                else report_failure($sformatf("error imem_addr: got %h, expected %h",
                                              imem_addr, ref_pc));
            next_pc = ref_pc + 32'd4;
            for (int b = 0; b < 3; b++) begin
                if (ref_pc == br_pc[b] && taken_left[b] > 0) begin
                    next_pc = ref_pc + br_off[b];
                    taken_left[b]--;
                end
            end
            ref_pc = next_pc;
        end
    end

    initial begin
        int waited;
        for (int b = 0; b < 3; b++) begin
            taken_left[b] = br_taken[b];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end

        expect_store(32'h88, 32'h0);   // Reset PC store, held off until rst drops
        expect_store(32'h40, x1_val);
        expect_store(32'h44, x2_val);
        expect_store(32'h48, x3_val);
        expect_store(32'h4C, slt_ref(x1_val, 32'hFFFF_FFFC));
        expect_store(32'h50, x1_val + x5_val);
        expect_store(32'h54, x1_val - x5_val);
        expect_store(32'h58, x2_val & x5_val);
        expect_store(32'h5C, x3_val | x5_val);
        expect_store(32'h60, slt_ref(x1_val, x5_val));   // Negative below positive
        expect_store(32'h64, slt_ref(x5_val, x1_val));
        expect_store(32'h6C, fill_word(2) + x5_val);      // Loaded word plus x5
        expect_store(32'h70, x5_val);
        for (int n = 1; n <= 3; n++) begin
            expect_store(32'h80, 32'd5 * n);   // One per loop pass
        end
        expect_store(32'h84, 32'h0);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < exp_addr.size(); k++) begin
            waited = 0;
            @(negedge clk);
            while (dmem_we !== 1'b1) begin
                waited++;
                if (waited >= store_timeout) begin
                    report_failure($sformatf("store %0d to address %h never appeared",
                                             k, exp_addr[k]));
                end
                @(negedge clk);
            end
            assert (dmem_addr === exp_addr[k])
                else report_failure($sformatf("error dmem_addr: got %h, expected %h",
                                              dmem_addr, exp_addr[k]));
            assert (dmem_wdata === exp_data[k])
                else report_failure($sformatf("error dmem_wdata: got %h, expected %h",
                                              dmem_wdata, exp_data[k]));
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: project.f
design/rv_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/imm_extend.sv
design/reg_file.sv
design/alu.sv
design/rv_core.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/main_decoder.sv
  - design/alu_decoder.sv
  - design/imm_extend.sv
  - design/reg_file.sv
  - design/alu.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - sim/tb_rv_core.sv
